// File: bench/bus_stimulus.txt
# op addr wdata mask lat region expect, all hex; mask bit 1 upper strobe, bit 0 lower
# op 0 read, 1 write, 2 input word (expect = word index), 3 vblank then interrupt ack
0 000100 0000 3 0 1 a4a5
0 123456 0000 3 4 1 91f3
0 3ffffe 0000 3 8 1 5a5b
0 200000 0000 3 0 1 a5a5
0 ff0010 0000 3 2 2 a5b5
1 ff8000 1234 3 1 2 0000
0 91abcc 0000 3 3 3 0e69
1 900010 beef 1 2 3 0000
0 92fffe 0000 2 5 3 5a5b
0 700200 0000 3 0 4 a7a5
2 800000 0000 3 0 5 0000
2 800008 0000 3 0 5 0001
2 800010 0000 3 0 5 0002
0 800030 0000 3 0 5 ffff
0 800100 0000 3 0 7 ffff
0 800140 0000 3 0 8 c33c
1 800040 7008 3 0 5 0000
1 800040 2000 2 0 5 0000
1 800040 0000 1 0 5 0000
0 600000 0000 3 6 6 ff5a
0 61fff0 0000 1 0 6 ff5a
0 a00000 0000 3 0 0 ffff
3 fffff4 0000 3 1 2 5a51

// File: filelist.f
hw/cps_map_pkg.sv
hw/cps_io_pkg.sv
hw/cpu_bus_if.sv
hw/region_sel_if.sv
hw/addr_decode.sv
hw/io_regs.sv
hw/bus_timing.sv
hw/cps2_main_bus.sv
bench/tb_cps2_main_bus.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cps2_main_bus -o tb_sim -f filelist.f > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "build or run stopped early, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qx "Done: no errors" sim.log 2>/dev/null && echo "simulation passed" && exit 0
echo "simulation failed"
exit 1

// File: bench/tb_cps2_main_bus.sv
`timescale 1ns/1ps

module tb_cps2_main_bus;
    import cps_map_pkg::*;
    import cps_io_pkg::*;

    localparam int TIMEOUT = 200;

    logic clk, rst, cen16;
    logic asn, rnw, udsn, ldsn;
    logic [ADDR_W:1] addr;
    logic [DATA_W-1:0] wdata, cpu_din, rom_data, ram_data, mmr_dout;
    logic [2:0] fc;
    logic dtackn, ipl1n, udswn, ldswn;
    logic rom_cs, ram_cs, vram_cs, oram_cs, qs_cs, ppu1_cs, ppu2_cs;
    logic rom_ok, ram_ok, qs_waitn, qs_busakn, lvbl;
    logic [21:1] rom_addr;
    logic [SDRAM_AW:1] sdram_addr;
    logic [ADDR_W:1] qs_addr;
    logic [7:0] qs_din;
    logic z80_rstn, eeprom_sclk, eeprom_sdi, eeprom_scs, eeprom_sdo, dip_test;
    logic [JOY_W-1:0] joystick1, joystick2, joystick3, joystick4;
    logic [3:0] start_button, coin_input;

    logic [23:0] cur_addr;
    int cur_lat;
    int rom_cnt, ram_cnt, qs_cnt;
    int errors;
    int seed;
    logic exp_sdi, exp_sclk, exp_scs, exp_z80;
    string op_names[4] = '{"read", "write", "input", "iack"};

    cps2_main_bus #(.FAIL_W(4)) uut (.*);

    // CPU drives byte addresses, bit 0 never reaches the bus
    assign addr     = cur_addr[23:1];
    assign rom_data = cur_addr[15:0] ^ 16'hA5A5;
    assign ram_data = cur_addr[15:0] ^ 16'hA5A5;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memories answer after the latency of the current line,
    // the sound CPU grants its bus after the same count
    initial begin
        cen16 = 1'b0;
        rom_ok = 1'b0;
        ram_ok = 1'b0;
        qs_busakn = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            cen16 = ~cen16;
            rom_cnt = rom_cs ? rom_cnt + 1 : 0;
            ram_cnt = (ram_cs | vram_cs | oram_cs) ? ram_cnt + 1 : 0;
            qs_cnt = qs_cs ? qs_cnt + 1 : 0;
            rom_ok = rom_cnt > cur_lat;
            ram_ok = ram_cnt > cur_lat;
            qs_busakn = !(qs_cnt > cur_lat);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // cabinet words as the board packs them
    function automatic logic [15:0] input_word(input logic [1:0] idx);
        case (idx)
            2'd0: return {joystick2[7:0], joystick1[7:0]};
            2'd1: return {joystick4[7:0], joystick3[7:0]};
            default: return {4'h0, coin_input, start_button, 2'b11, dip_test, eeprom_sdo};
        endcase
    endfunction

    // order: rom, ram, vram, oram, qs, ppu1, ppu2
    function automatic logic [6:0] select_mask(input int region);
        case (region)
            1: return 7'b1000000;
            2: return 7'b0100000;
            3: return 7'b0010000;
            4: return 7'b0001000;
            6: return 7'b0000100;
            7: return 7'b0000010;
            8: return 7'b0000001;
            default: return 7'b0000000;
        endcase
    endfunction

    function automatic string region_name(input int region);
        mem_region_e r;
        if (region == 7) return "PPU1";
        if (region == 8) return "PPU2";
        r = mem_region_e'(region[2:0]);
        return r.name();
    endfunction

    task automatic run_test(input int num, input int op, input logic [23:0] a,
                            input logic [15:0] wd, input logic [1:0] mask, input int lat,
                            input int region, input logic [15:0] exp_word);
        int start_errs;
        int n;
        logic done;
        logic [15:0] want;
        start_errs = errors;
        done = 1'b0;
        want = (op == 2) ? input_word(exp_word[1:0]) : exp_word;
        if (op == 3) begin
            @(posedge clk);
            #1 lvbl = 1'b0;
            for (n = 0; n < TIMEOUT && ipl1n; n++) @(negedge clk);
            if (ipl1n) begin
                $display("test %0d: ipl1n never went low after the vblank edge", num);
                errors++;
            end
            @(posedge clk);
            #1 lvbl = 1'b1;
        end
        @(posedge clk);
        #1;
        cur_lat = lat;
        cur_addr = a;
        wdata = wd;
        rnw = (op != 1);
        fc = (op == 3) ? 3'b111 : 3'b101;
        asn = 1'b0;
        udsn = !mask[1];
        ldsn = !mask[0];
        for (n = 0; n < TIMEOUT && !done; n++) begin
            @(negedge clk);
            done = !dtackn;
        end
        if (!done) begin
            $display("test %0d: dtackn never went low, access timed out", num);
            errors++;
        end else begin
            check_value("selects", 32'({rom_cs, ram_cs, vram_cs, oram_cs, qs_cs,
                        ppu1_cs, ppu2_cs}), 32'(select_mask(region)));
            if (op != 1) check_value("cpu_din", 32'(cpu_din), 32'(want));
            check_value("udswn", 32'(udswn), 32'((op != 1) || !mask[1]));
            check_value("ldswn", 32'(ldswn), 32'((op != 1) || !mask[0]));
            case (region)
                1: begin
                    check_value("rom_ok", 32'(rom_ok), 32'd1);
                    check_value("rom_addr", 32'(rom_addr), 32'(a[21:1]));
                end
                2: begin
                    check_value("ram_ok", 32'(ram_ok), 32'd1);
                    check_value("sdram_addr", 32'(sdram_addr), 32'({2'b00, a[15:1]}));
                end
                3, 4: begin
                    check_value("ram_ok", 32'(ram_ok), 32'd1);
                    check_value("sdram_addr", 32'(sdram_addr), 32'(a[17:1]));
                end
                6: begin
                    check_value("qs_busakn", 32'(qs_busakn), 32'd0);
                    check_value("qs_addr", 32'(qs_addr), 32'(a[23:1]));
                end
                default: ;
            endcase
        end
        @(posedge clk);
        #1;
        asn = 1'b1;
        udsn = 1'b1;
        ldsn = 1'b1;
        rnw = 1'b1;
        fc = 3'b101;
        // one full clk after asn rises
        @(posedge clk);
        @(negedge clk);
        check_value("dtackn", 32'(dtackn), 32'd1);
        check_value("selects after asn", 32'({rom_cs, qs_cs, ppu1_cs, ppu2_cs}), 32'd0);
        if (op == 3) check_value("ipl1n", 32'(ipl1n), 32'd1);
        if (op == 1 && region == 5 && io_reg_e'(a[8:3]) == IO_OUT) begin
            if (mask[1]) begin
                exp_sdi = wd[EE_SDI_BIT];
                exp_sclk = wd[EE_SCLK_BIT];
                exp_scs = wd[EE_SCS_BIT];
            end
            if (mask[0]) exp_z80 = wd[Z80_RST_BIT];
        end
        check_value("eeprom_sdi", 32'(eeprom_sdi), 32'(exp_sdi));
        check_value("eeprom_sclk", 32'(eeprom_sclk), 32'(exp_sclk));
        check_value("eeprom_scs", 32'(eeprom_scs), 32'(exp_scs));
        check_value("z80_rstn", 32'(z80_rstn), 32'(exp_z80));
        repeat (4) @(posedge clk);
        $display("test %0d %s %s 0x%06h: %0d errors", num, op_names[op[1:0]],
                 region_name(region), a, errors - start_errs);
    endtask

    initial begin
        int fd;
        int code;
        int num;
        int op;
        int lat;
        int region;
        logic [23:0] a;
        logic [15:0] wd;
        logic [15:0] word;
        logic [1:0] mask;
        string line;
        num = 0;
        errors = 0;
        seed = 32'hbb72_7883;
        rst = 1'b1;
        asn = 1'b1;
        udsn = 1'b1;
        ldsn = 1'b1;
        rnw = 1'b1;
        fc = 3'b101;
        cur_addr = 24'h0;
        cur_lat = 0;
        wdata = 16'h0;
        lvbl = 1'b1;
        qs_waitn = 1'b1;
        qs_din = 8'h5A;
        mmr_dout = 16'hC33C;
        joystick1 = JOY_W'($random(seed));
        joystick2 = JOY_W'($random(seed));
        joystick3 = JOY_W'($random(seed));
        joystick4 = JOY_W'($random(seed));
        start_button = 4'($random(seed));
        coin_input = 4'($random(seed));
        dip_test = 1'($random(seed));
        eeprom_sdo = 1'($random(seed));
        exp_sdi = 1'b0;
        exp_sclk = 1'b0;
        exp_scs = 1'b0;
        exp_z80 = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        fd = $fopen("bench/bus_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/bus_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h",
                                   op, a, wd, mask, lat, region, word);
                    if (code == 7) begin
                        num++;
                        run_test(num, op, a, wd, mask, lat, region, word);
                    end
                end
            end
            $fclose(fd);
        end
        $display("tests run: %0d, errors: %0d", num, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: hw/cps2_main_bus.sv
`timescale 1ns/1ps

module cps2_main_bus #(
    parameter int FAIL_W = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cen16,
    input  logic                           asn,
    input  logic                           rnw,
    input  logic                           udsn,
    input  logic                           ldsn,
    input  logic [cps_map_pkg::ADDR_W:1]   addr,
    input  logic [cps_map_pkg::DATA_W-1:0] wdata,
    input  logic [2:0]                     fc,
    output logic [cps_map_pkg::DATA_W-1:0] cpu_din,
    output logic                           dtackn,
    output logic                           ipl1n,
    output logic                           udswn,
    output logic                           ldswn,
    output logic                           rom_cs,
    output logic [21:1]                    rom_addr,
    input  logic [cps_map_pkg::DATA_W-1:0] rom_data,
    input  logic                           rom_ok,
    output logic                           ram_cs,
    output logic                           vram_cs,
    output logic                           oram_cs,
    output logic [cps_map_pkg::SDRAM_AW:1] sdram_addr,
    input  logic [cps_map_pkg::DATA_W-1:0] ram_data,
    input  logic                           ram_ok,
    output logic                           ppu1_cs,
    output logic                           ppu2_cs,
    input  logic [cps_map_pkg::DATA_W-1:0] mmr_dout,
    output logic                           qs_cs,
    output logic [cps_map_pkg::ADDR_W:1]   qs_addr,
    input  logic [7:0]                     qs_din,
    input  logic                           qs_waitn,
    input  logic                           qs_busakn,
    output logic                           z80_rstn,
    input  logic [cps_io_pkg::JOY_W-1:0]   joystick1,
    input  logic [cps_io_pkg::JOY_W-1:0]   joystick2,
    input  logic [cps_io_pkg::JOY_W-1:0]   joystick3,
    input  logic [cps_io_pkg::JOY_W-1:0]   joystick4,
    input  logic [3:0]                     start_button,
    input  logic [3:0]                     coin_input,
    input  logic                           dip_test,
    input  logic                           eeprom_sdo,
    output logic                           eeprom_sclk,
    output logic                           eeprom_sdi,
    output logic                           eeprom_scs,
    input  logic                           lvbl
);

    cpu_bus_if    bus ();
    region_sel_if sel ();

    // CPU pins onto the internal bus
    assign bus.addr  = addr;
    assign bus.rnw   = rnw;
    assign bus.asn   = asn;
    assign bus.udsn  = udsn;
    assign bus.ldsn  = ldsn;
    assign bus.wdata = wdata;
    assign bus.fc    = fc;

    assign rom_cs = sel.rom_cs;
    assign qs_cs  = sel.qs_cs;

    addr_decode u_decode (
        .bus (bus),
        .sel (sel),
        .*
    );

    io_regs u_io (
        .bus (bus),
        .sel (sel),
        .*
    );

    bus_timing #(
        .FAIL_W (FAIL_W)
    ) u_timing (
        .bus (bus),
        .sel (sel),
        .*
    );

endmodule

// File: hw/bus_timing.sv
`timescale 1ns/1ps

module bus_timing #(
    parameter int FAIL_W = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen16,
    cpu_bus_if.listener bus,
    region_sel_if.dst   sel,
    input  logic        ram_ok,
    input  logic        rom_ok,
    input  logic        qs_waitn,
    input  logic        qs_busakn,
    input  logic        lvbl,
    output logic        dtackn,
    output logic        ipl1n
);

    typedef enum logic [1:0] {
        BT_IDLE,
        BT_WAIT,
        BT_ACK
    } bt_state_e;

    bt_state_e         state;
    logic [2:0]        wait_sr;
    logic [FAIL_W-1:0] fail_cnt;
    logic              fail_ok;
    logic              rom_ok_d;
    logic              busakn_s;
    logic              last_lvbl;
    logic              ram_any;
    logic              mem_cs;
    logic              mem_busy;
    logic              lvbl_fall;
    logic              inta;

    assign ram_any   = sel.ram_cs_pre | sel.vram_cs_pre | sel.oram_cs_pre;
    assign mem_cs    = sel.rom_cs | ram_any;
    // rom_ok taken one clk late so the ROM word reaches the data mux first
    assign mem_busy  = (sel.rom_cs & ~rom_ok_d) | (ram_any & ~ram_ok);
    assign lvbl_fall = !lvbl && last_lvbl;
    assign inta      = !bus.asn && bus.fc == 3'b111;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_ok_d  <= 1'b0;
            busakn_s  <= 1'b1;
            last_lvbl <= 1'b0;
        end else begin
            rom_ok_d  <= rom_ok;
            last_lvbl <= lvbl;
            if (cen16) begin
                busakn_s <= qs_busakn;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= BT_IDLE;
            dtackn   <= 1'b1;
            wait_sr  <= 3'b111;
            fail_cnt <= '0;
            fail_ok  <= 1'b0;
        end else begin
            // SDRAM ready, so delay accounting can begin
            if (rom_ok) begin
                fail_ok <= 1'b1;
            end
            case (state)
                BT_IDLE: begin
                    dtackn  <= 1'b1;
                    wait_sr <= 3'b111;
                    if (!bus.asn) begin
                        state <= BT_WAIT;
                    end
                end
                BT_WAIT: begin
                    if (bus.asn) begin
                        state <= BT_IDLE;
                    end else if (mem_cs) begin
                        if (cen16) begin
                            wait_sr <= {1'b0, wait_sr[2:1]};
                        end
                        if (!mem_busy && (!wait_sr[0] || (fail_cnt != '0 && !wait_sr[1]))) begin
                            state  <= BT_ACK;
                            dtackn <= 1'b0;
                            // early ack pays back one tick of past delay
                            if (wait_sr[0]) begin
                                fail_cnt <= fail_cnt - FAIL_W'(1);
                            end
                        end else if (!wait_sr[0] && fail_ok && fail_cnt == '0) begin
                            fail_cnt <= fail_cnt + FAIL_W'(1);
                        end
                    end else if (sel.qs_cs) begin
                        // wait for the sound CPU to hand over its bus
                        if (!busakn_s && qs_waitn) begin
                            state  <= BT_ACK;
                            dtackn <= 1'b0;
                        end
                    end else begin
                        state  <= BT_ACK;
                        dtackn <= 1'b0;
                    end
                end
                BT_ACK: begin
                    if (bus.asn) begin
                        state  <= BT_IDLE;
                        dtackn <= 1'b1;
                    end
                end
                default: state <= BT_IDLE;
            endcase
            // recovery restarts every frame
            if (lvbl_fall) begin
                fail_cnt <= '0;
            end
        end
    end

    // vertical blank on level 2, cleared by the acknowledge cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ipl1n <= 1'b1;
        end else if (inta) begin
            ipl1n <= 1'b1;
        end else if (lvbl_fall) begin
            ipl1n <= 1'b0;
        end
    end

    a_dtack_release: assert property (@(posedge clk) disable iff (rst)
        bus.asn |=> dtackn);

endmodule

// File: hw/io_regs.sv
`timescale 1ns/1ps

module io_regs (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cen16,
    cpu_bus_if.listener                      bus,
    region_sel_if.dst                        sel,
    input  logic                             ram_cs,
    input  logic                             vram_cs,
    input  logic                             oram_cs,
    input  logic [cps_io_pkg::JOY_W-1:0]     joystick1,
    input  logic [cps_io_pkg::JOY_W-1:0]     joystick2,
    input  logic [cps_io_pkg::JOY_W-1:0]     joystick3,
    input  logic [cps_io_pkg::JOY_W-1:0]     joystick4,
    input  logic [3:0]                       start_button,
    input  logic [3:0]                       coin_input,
    input  logic                             dip_test,
    input  logic                             eeprom_sdo,
    input  logic [cps_map_pkg::DATA_W-1:0]   ram_data,
    input  logic [cps_map_pkg::DATA_W-1:0]   rom_data,
    input  logic [cps_map_pkg::DATA_W-1:0]   mmr_dout,
    input  logic [7:0]                       qs_din,
    output logic [cps_map_pkg::DATA_W-1:0]   cpu_din,
    output logic                             ppu1_cs,
    output logic                             ppu2_cs,
    output logic                             eeprom_sclk,
    output logic                             eeprom_sdi,
    output logic                             eeprom_scs,
    output logic                             z80_rstn
);
    import cps_map_pkg::*;
    import cps_io_pkg::*;

    io_reg_e           offs;
    logic              sys_cs;
    logic              out_wr;
    logic [DATA_W-1:0] in0;
    logic [DATA_W-1:0] in1;
    logic [DATA_W-1:0] in2;
    logic [DATA_W-1:0] sys_data;

    assign offs    = io_reg_e'(bus.addr[8:3]);
    assign ppu1_cs = sel.io_cs && bus.addr[8:6] == PPU_A_PAGE;
    assign ppu2_cs = sel.io_cs && bus.addr[8:6] == PPU_B_PAGE;
    // any read inside the system register block
    assign sys_cs  = sel.io_cs && bus.rnw &&
                     offs inside {IO_IN0, IO_IN1, IO_IN2, IO_VOL, IO_OUT};
    assign out_wr  = sel.io_cs && !bus.rnw && offs == IO_OUT;

    always_ff @(posedge clk) begin
        in0 <= {joystick2[7:0], joystick1[7:0]};
        in1 <= {joystick4[7:0], joystick3[7:0]};
        // upper nibble unused
        in2 <= {4'h0, coin_input, start_button, 2'b11, dip_test, eeprom_sdo};
    end

    // volume and output registers are write-only
    always_ff @(posedge clk) begin
        case (offs)
            IO_IN0:  sys_data <= in0;
            IO_IN1:  sys_data <= in1;
            IO_IN2:  sys_data <= in2;
            default: sys_data <= '1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (sys_cs) begin
            cpu_din <= sys_data;
        end else if (ram_cs | vram_cs | oram_cs) begin
            cpu_din <= ram_data;
        end else if (sel.rom_cs) begin
            cpu_din <= rom_data;
        end else if (ppu2_cs) begin
            cpu_din <= mmr_dout;
        end else if (sel.qs_cs) begin
            cpu_din <= {8'hFF, qs_din};
        end else begin
            cpu_din <= '1;
        end
    end

    // EEPROM pins sit in the upper byte, sound reset in the lower
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            eeprom_sdi  <= 1'b0;
            eeprom_sclk <= 1'b0;
            eeprom_scs  <= 1'b0;
            z80_rstn    <= 1'b0;
        end else if (cen16 && out_wr) begin
            if (!bus.udsn) begin
                eeprom_sdi  <= bus.wdata[EE_SDI_BIT];
                eeprom_sclk <= bus.wdata[EE_SCLK_BIT];
                eeprom_scs  <= bus.wdata[EE_SCS_BIT];
            end
            if (!bus.ldsn) begin
                z80_rstn <= bus.wdata[Z80_RST_BIT];
            end
        end
    end

endmodule

// File: hw/addr_decode.sv
`timescale 1ns/1ps

module addr_decode (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cen16,
    cpu_bus_if.listener                    bus,
    region_sel_if.src                      sel,
    output logic                           ram_cs,
    output logic                           vram_cs,
    output logic                           oram_cs,
    output logic [cps_map_pkg::SDRAM_AW:1] sdram_addr,
    output logic [21:1]                    rom_addr,
    output logic [cps_map_pkg::ADDR_W:1]   qs_addr,
    output logic                           udswn,
    output logic                           ldswn
);
    import cps_map_pkg::*;

    mem_region_e       region;
    logic [SDRAM_AW:1] mem_addr;
    logic              held_ram_cs;
    logic              held_vram_cs;
    logic              held_oram_cs;
    logic              dsn_dly;

    always_comb begin
        region = REG_NONE;
        if (bus.addr[23:22] == ROM_TOP) begin
            region = REG_ROM;
        end else if (bus.addr[23:16] == RAM_TOP) begin
            region = REG_RAM;
        end else if (bus.addr[23:16] >= VRAM_LO && bus.addr[23:16] <= VRAM_HI) begin
            region = REG_VRAM;
        end else if (bus.addr[23:16] == ORAM_TOP) begin
            region = REG_ORAM;
        end else if (bus.addr[23:19] == IO_TOP) begin
            region = REG_IO;
        end else if (bus.addr[23:17] == QS_TOP) begin
            region = REG_QS;
        end
    end

    // selects drop on the first clk with asn high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel.rom_cs      <= 1'b0;
            sel.ram_cs_pre  <= 1'b0;
            sel.vram_cs_pre <= 1'b0;
            sel.oram_cs_pre <= 1'b0;
            sel.io_cs       <= 1'b0;
            sel.qs_cs       <= 1'b0;
        end else begin
            sel.rom_cs      <= !bus.asn && region == REG_ROM;
            sel.ram_cs_pre  <= !bus.asn && region == REG_RAM;
            sel.vram_cs_pre <= !bus.asn && region == REG_VRAM;
            sel.oram_cs_pre <= !bus.asn && region == REG_ORAM;
            sel.io_cs       <= !bus.asn && region == REG_IO;
            sel.qs_cs       <= !bus.asn && region == REG_QS;
        end
    end

    always_ff @(posedge clk) begin
        if (!bus.asn) begin
            rom_addr <= bus.addr[21:1];
            qs_addr  <= bus.addr;
            mem_addr <= bus.addr[SDRAM_AW:1];
        end
    end

    assign udswn = bus.rnw | bus.udsn;
    assign ldswn = bus.rnw | bus.ldsn;

    // the RAM selects fall before the write strobes do, which would start
    // a spurious SDRAM read, so hold them until a strobe tick has passed
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_ram_cs  <= 1'b0;
            held_vram_cs <= 1'b0;
            held_oram_cs <= 1'b0;
            dsn_dly      <= 1'b1;
        end else if (cen16) begin
            held_ram_cs  <= sel.ram_cs_pre;
            held_vram_cs <= sel.vram_cs_pre;
            held_oram_cs <= sel.oram_cs_pre;
            // low while either write strobe is active
            dsn_dly      <= udswn & ldswn;
        end
    end

    assign ram_cs  = dsn_dly ? held_ram_cs  : sel.ram_cs_pre;
    assign vram_cs = dsn_dly ? held_vram_cs : sel.vram_cs_pre;
    assign oram_cs = dsn_dly ? held_oram_cs : sel.oram_cs_pre;

    // work RAM and video RAM share one SDRAM bank
    assign sdram_addr = ram_cs ? {2'b00, mem_addr[SDRAM_AW-2:1]} : mem_addr;

    // held RAM selects must not overlap the next region
    a_region_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({sel.rom_cs, ram_cs, vram_cs,
                  oram_cs, sel.io_cs, sel.qs_cs}));

endmodule

// File: hw/region_sel_if.sv
`timescale 1ns/1ps

interface region_sel_if;

    logic rom_cs;
    // unguarded RAM selects, straight from the address match
    logic ram_cs_pre;
    logic vram_cs_pre;
    logic oram_cs_pre;
    logic io_cs;
    logic qs_cs;

    modport src (
        output rom_cs, ram_cs_pre, vram_cs_pre, oram_cs_pre, io_cs, qs_cs
    );

    modport dst (
        input rom_cs, ram_cs_pre, vram_cs_pre, oram_cs_pre, io_cs, qs_cs
    );

endinterface

// File: hw/cpu_bus_if.sv
`timescale 1ns/1ps

interface cpu_bus_if;
    import cps_map_pkg::*;

    logic [ADDR_W:1]   addr;
    logic              rnw;
    logic              asn;
    logic              udsn;
    logic              ldsn;
    logic [DATA_W-1:0] wdata;
    logic [2:0]        fc;

    // bus master side
    modport driver (
        output addr, rnw, asn, udsn, ldsn, wdata, fc
    );

    // decoders and timing blocks
    modport listener (
        input addr, rnw, asn, udsn, ldsn, wdata, fc
    );

endinterface

// File: hw/cps_io_pkg.sv
package cps_io_pkg;

    // register offsets on address bits 8 to 3
    typedef enum logic [5:0] {
        IO_IN0 = 6'h00,
        IO_IN1 = 6'h01,
        IO_IN2 = 6'h02,
        IO_VOL = 6'h06,
        IO_OUT = 6'h08
    } io_reg_e;

    // video chip pages on address bits 8 to 6
    localparam logic [2:0] PPU_A_PAGE = 3'b100;
    localparam logic [2:0] PPU_B_PAGE = 3'b101;

    localparam int JOY_W = 10;

    // EEPROM pins in the upper byte of an OUT write
    localparam int EE_SDI_BIT  = 12;
    localparam int EE_SCLK_BIT = 13;
    localparam int EE_SCS_BIT  = 14;
    localparam int Z80_RST_BIT = 3;

endpackage

// File: hw/cps_map_pkg.sv
package cps_map_pkg;

    // 68000 word address, bits 23 down to 1
    localparam int ADDR_W   = 23;
    localparam int DATA_W   = 16;
    localparam int SDRAM_AW = 17;

    typedef enum logic [2:0] {
        REG_NONE,
        REG_ROM,
        REG_RAM,
        REG_VRAM,
        REG_ORAM,
        REG_IO,
        REG_QS
    } mem_region_e;

    // program ROM, 000000-3FFFFF
    localparam logic [1:0] ROM_TOP  = 2'b00;
    // work RAM, FF0000-FFFFFF
    localparam logic [7:0] RAM_TOP  = 8'hFF;

    // video RAM spans three 64k banks
    localparam logic [7:0] VRAM_LO  = 8'h90;
    localparam logic [7:0] VRAM_HI  = 8'h92;

    // object RAM, 700000-70FFFF
    localparam logic [7:0] ORAM_TOP = 8'h70;
    // I/O page, 800000-87FFFF
    localparam logic [4:0] IO_TOP   = 5'b10000;
    // sound CPU shared window, 600000-61FFFF
    localparam logic [6:0] QS_TOP   = 7'b0110000;

endpackage
